// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sim.f --top-module tb_calc \
		--Mdir obj_dir -o tb_calc
	./obj_dir/tb_calc

clean:
	rm -rf obj_dir

// ==== common/calc_pkg.sv ====
// Shared widths, operation codes and packet types for the integer execution back end
`default_nettype none

package calc_pkg;

  localparam int data_width_c = 32;

  // Completion depth counts the reservation as stage 0
  localparam int comp_stages_c = 3;

  typedef logic [data_width_c-1:0] data_t;
  typedef logic [4:0]              reg_addr_t;
  typedef logic [5:0]              div_count_t;

  typedef enum logic [2:0]
  {
    op_add,
    op_sub,
    op_and,
    op_xor,
    op_sltu,
    op_mul,
    op_divu,
    op_remu
  } calc_op_e;

  typedef struct packed
  {
    logic      v;
    calc_op_e  op;
    logic      rs1_r_v;
    logic      rs2_r_v;
    logic      rd_w_v;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;
    data_t     rs1;
    data_t     rs2;
  } dispatch_pkt_t;

  typedef struct packed
  {
    logic      w_v;
    reg_addr_t rd_addr;
    data_t     rd_data;
  } wb_pkt_t;

endpackage

`default_nettype wire

// ==== hw/calc_bypass.sv ====
// Operand bypass network, forwards in-flight results to the instruction being dispatched
`timescale 1ns/1ps
`default_nettype none

module calc_bypass
  (
    input  calc_pkg::dispatch_pkt_t dispatch_pkt_i,
    input  calc_pkg::wb_pkt_t       stage0_i,
    input  calc_pkg::wb_pkt_t       stage1_n_i,
    input  calc_pkg::wb_pkt_t       stage1_i,
    input  calc_pkg::wb_pkt_t       stage2_n_i,
    input  calc_pkg::wb_pkt_t       iwb_pkt_i,
    output calc_pkg::data_t         rs1_o,
    output calc_pkg::data_t         rs2_o
  );

  import calc_pkg::*;

  // Index 0 is the youngest source
  wb_pkt_t [comp_stages_c-1:0] src_tag;
  data_t   [comp_stages_c-1:0] src_data;
  logic    [comp_stages_c-1:0] rs1_match;
  logic    [comp_stages_c-1:0] rs2_match;

  // A stage tag pairs with the data being written into the next stage
  assign src_tag  = {iwb_pkt_i, stage1_i, stage0_i};
  assign src_data = {iwb_pkt_i.rd_data, stage2_n_i.rd_data, stage1_n_i.rd_data};

  for (genvar i = 0; i < comp_stages_c; i++)
  begin : g_match
    assign rs1_match[i] = dispatch_pkt_i.rs1_r_v & src_tag[i].w_v
                          & (src_tag[i].rd_addr == dispatch_pkt_i.rs1_addr);
    assign rs2_match[i] = dispatch_pkt_i.rs2_r_v & src_tag[i].w_v
                          & (src_tag[i].rd_addr == dispatch_pkt_i.rs2_addr);
  end

  // Oldest first so the youngest match is applied last
  always_comb
  begin
    rs1_o = dispatch_pkt_i.rs1;
    rs2_o = dispatch_pkt_i.rs2;
    for (int i = comp_stages_c - 1; i >= 0; i--)
    begin
      if (rs1_match[i])
        rs1_o = src_data[i];
      if (rs2_match[i])
        rs2_o = src_data[i];
    end
  end

endmodule

`default_nettype wire

// ==== hw/calc_comp_pipe.sv ====
// Completion pipeline, merges pipe results into stage registers and arbitrates the writeback port
`timescale 1ns/1ps
`default_nettype none

module calc_comp_pipe
  (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  calc_pkg::dispatch_pkt_t reservation_i,
    input  calc_pkg::data_t         int_data_i,
    input  logic                    int_v_i,
    input  calc_pkg::data_t         mul_data_i,
    input  logic                    mul_v_i,
    input  calc_pkg::wb_pkt_t       long_pkt_i,
    input  logic                    long_v_i,
    output logic                    long_yumi_o,
    output calc_pkg::wb_pkt_t       stage0_o,
    output calc_pkg::wb_pkt_t       stage1_n_o,
    output calc_pkg::wb_pkt_t       stage1_o,
    output calc_pkg::wb_pkt_t       stage2_n_o,
    output calc_pkg::wb_pkt_t       iwb_pkt_o
  );

  import calc_pkg::*;

  wb_pkt_t                     stage0;
  wb_pkt_t [comp_stages_c-1:1] stage_n;
  wb_pkt_t [comp_stages_c-1:1] stage_r;

  // Divides write back on their own, so their tag never writes
  assign stage0.w_v     = reservation_i.v & reservation_i.rd_w_v
                          & ~(reservation_i.op inside {op_divu, op_remu});
  assign stage0.rd_addr = reservation_i.rd_addr;
  assign stage0.rd_data = '0;

  always_comb
  begin
    stage_n[1] = stage0;
    for (int i = 2; i < comp_stages_c; i++)
      stage_n[i] = stage_r[i-1];
    stage_n[1].rd_data |= int_v_i ? int_data_i : '0;
    stage_n[2].rd_data |= mul_v_i ? mul_data_i : '0;
  end

  always_ff @(posedge clk_i)
  begin
    stage_r <= stage_n;
    if (rst_i)
    begin
      for (int i = 1; i < comp_stages_c; i++)
        stage_r[i].w_v <= 1'b0;
    end
  end

  // Divide result slips in whenever the last stage is idle
  assign long_yumi_o = long_v_i & ~stage_r[comp_stages_c-1].w_v;
  assign iwb_pkt_o   = long_yumi_o ? long_pkt_i : stage_r[comp_stages_c-1];

  assign stage0_o   = stage0;
  assign stage1_n_o = stage_n[1];
  assign stage1_o   = stage_r[1];
  assign stage2_n_o = stage_n[2];

  // Each stage gets data from at most one pipe per instruction
  a_single_source: assert property (
    @(posedge clk_i) disable iff (rst_i)
    mul_v_i |-> (stage_r[1].rd_data == '0)
  );

endmodule

`default_nettype wire

// ==== hw/calc_pipe_int.sv ====
// Single-cycle integer ALU working straight off the reservation register
`timescale 1ns/1ps
`default_nettype none

module calc_pipe_int
  (
    input  calc_pkg::dispatch_pkt_t reservation_i,
    output calc_pkg::data_t         data_o,
    output logic                    v_o
  );

  import calc_pkg::*;

  data_t src1;
  data_t src2;

  assign src1 = reservation_i.rs1;
  assign src2 = reservation_i.rs2;

  always_comb
  begin
    case (reservation_i.op)
      op_add:  data_o = src1 + src2;
      op_sub:  data_o = src1 - src2;
      op_and:  data_o = src1 & src2;
      op_xor:  data_o = src1 ^ src2;
      op_sltu: data_o = data_t'(src1 < src2);
      default: data_o = '0;
    endcase
  end

  // Valid only for ops that complete here
  assign v_o = reservation_i.v
               & (reservation_i.op inside {op_add, op_sub, op_and, op_xor, op_sltu});

endmodule

`default_nettype wire

// ==== hw/calc_pipe_long.sv ====
// Iterative unsigned divide and remainder unit, holds its result until the writeback accepts it
`timescale 1ns/1ps
`default_nettype none

module calc_pipe_long
  (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  calc_pkg::dispatch_pkt_t reservation_i,
    output logic                    busy_o,
    output calc_pkg::wb_pkt_t       wb_pkt_o,
    output logic                    v_o,
    input  logic                    yumi_i
  );

  import calc_pkg::*;

  typedef enum logic [1:0]
  {
    state_idle,
    state_busy,
    state_done
  } state_e;

  state_e     state_r;
  state_e     state_n;
  data_t      quot_r;
  data_t      rem_r;
  data_t      divisor_r;
  div_count_t count_r;
  reg_addr_t  rd_addr_r;
  logic       rem_sel_r;
  logic       start;
  logic       last_iter;

  logic [data_width_c:0] shifted;
  logic [data_width_c:0] diff;

  assign start     = reservation_i.v & (reservation_i.op inside {op_divu, op_remu});
  assign last_iter = (state_r == state_busy)
                     & (count_r == div_count_t'(data_width_c - 1));

  // Restoring step, a borrow out of diff means the trial subtract failed
  assign shifted = {rem_r, quot_r[data_width_c-1]};
  assign diff    = shifted - {1'b0, divisor_r};

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      state_idle: if (start) state_n = state_busy;
      state_busy: if (last_iter) state_n = state_done;
      state_done: if (yumi_i) state_n = state_idle;
      default:    state_n = state_idle;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      state_r <= state_idle;
    else
      state_r <= state_n;
  end

  // Divide by zero falls out naturally as all ones and the dividend
  always_ff @(posedge clk_i)
  begin
    if (start)
    begin
      quot_r    <= reservation_i.rs1;
      rem_r     <= '0;
      divisor_r <= reservation_i.rs2;
      count_r   <= '0;
      rd_addr_r <= reservation_i.rd_addr;
      rem_sel_r <= (reservation_i.op == op_remu);
    end
    else if (state_r == state_busy)
    begin
      quot_r  <= {quot_r[data_width_c-2:0], ~diff[data_width_c]};
      rem_r   <= diff[data_width_c] ? shifted[data_width_c-1:0] : diff[data_width_c-1:0];
      count_r <= count_r + 6'd1;
    end
  end

  assign v_o              = (state_r == state_done);
  assign busy_o           = (state_r != state_idle) | start;
  assign wb_pkt_o.w_v     = v_o;
  assign wb_pkt_o.rd_addr = rd_addr_r;
  assign wb_pkt_o.rd_data = rem_sel_r ? rem_r : quot_r;

  // Issuer must hold off divides while busy
  a_no_start_when_busy: assert property (
    @(posedge clk_i) disable iff (rst_i)
    start |-> (state_r == state_idle)
  );

endmodule

`default_nettype wire

// ==== hw/calc_pipe_mul.sv ====
// Two-cycle integer multiplier, returns the low word of the product
`timescale 1ns/1ps
`default_nettype none

module calc_pipe_mul
  (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  calc_pkg::dispatch_pkt_t reservation_i,
    output calc_pkg::data_t         data_o,
    output logic                    v_o
  );

  import calc_pkg::*;

  data_t product_r;
  logic  v_r;

  always_ff @(posedge clk_i)
  begin
    // Truncated to the operand width
    product_r <= reservation_i.rs1 * reservation_i.rs2;
    if (rst_i)
      v_r <= 1'b0;
    else
      v_r <= reservation_i.v & (reservation_i.op == op_mul);
  end

  assign data_o = product_r;
  assign v_o    = v_r;

endmodule

`default_nettype wire

// ==== hw/calc_top.sv ====
// Top level of the integer back end, holds the reservation register and wires up the pipes
`timescale 1ns/1ps
`default_nettype none

module calc_top
  (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  calc_pkg::dispatch_pkt_t dispatch_pkt_i,
    output calc_pkg::wb_pkt_t       iwb_pkt_o,
    output logic                    idiv_busy_o
  );

  import calc_pkg::*;

  dispatch_pkt_t reservation_n;
  dispatch_pkt_t reservation_r;
  data_t         bypass_rs1;
  data_t         bypass_rs2;
  data_t         int_data;
  logic          int_v;
  data_t         mul_data;
  logic          mul_v;
  wb_pkt_t       long_pkt;
  logic          long_v;
  logic          long_yumi;
  wb_pkt_t       stage0;
  wb_pkt_t       stage1_n;
  wb_pkt_t       stage1;
  wb_pkt_t       stage2_n;
  logic          mul_hazard;

  calc_bypass u_bypass
  (
    .dispatch_pkt_i (dispatch_pkt_i),
    .stage0_i       (stage0),
    .stage1_n_i     (stage1_n),
    .stage1_i       (stage1),
    .stage2_n_i     (stage2_n),
    .iwb_pkt_i      (iwb_pkt_o),
    .rs1_o          (bypass_rs1),
    .rs2_o          (bypass_rs2)
  );

  always_comb
  begin
    reservation_n     = dispatch_pkt_i;
    reservation_n.rs1 = bypass_rs1;
    reservation_n.rs2 = bypass_rs2;
  end

  always_ff @(posedge clk_i)
  begin
    reservation_r <= reservation_n;
    if (rst_i)
      reservation_r.v <= 1'b0;
  end

  calc_pipe_int u_pipe_int
  (
    .reservation_i (reservation_r),
    .data_o        (int_data),
    .v_o           (int_v)
  );

  calc_pipe_mul u_pipe_mul
  (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .reservation_i (reservation_r),
    .data_o        (mul_data),
    .v_o           (mul_v)
  );

  calc_pipe_long u_pipe_long
  (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .reservation_i (reservation_r),
    .busy_o        (idiv_busy_o),
    .wb_pkt_o      (long_pkt),
    .v_o           (long_v),
    .yumi_i        (long_yumi)
  );

  calc_comp_pipe u_comp_pipe
  (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .reservation_i (reservation_r),
    .int_data_i    (int_data),
    .int_v_i       (int_v),
    .mul_data_i    (mul_data),
    .mul_v_i       (mul_v),
    .long_pkt_i    (long_pkt),
    .long_v_i      (long_v),
    .long_yumi_o   (long_yumi),
    .stage0_o      (stage0),
    .stage1_n_o    (stage1_n),
    .stage1_o      (stage1),
    .stage2_n_o    (stage2_n),
    .iwb_pkt_o     (iwb_pkt_o)
  );

  // Multiply result is not yet available to the next dispatch
  assign mul_hazard = dispatch_pkt_i.v & reservation_r.v & reservation_r.rd_w_v
                      & (reservation_r.op == op_mul)
                      & ((dispatch_pkt_i.rs1_r_v
                          & (dispatch_pkt_i.rs1_addr == reservation_r.rd_addr))
                         | (dispatch_pkt_i.rs2_r_v
                          & (dispatch_pkt_i.rs2_addr == reservation_r.rd_addr)));

  a_no_mul_bypass: assert property (
    @(posedge clk_i) disable iff (rst_i)
    !mul_hazard
  );

endmodule

`default_nettype wire

// ==== sim.f ====
common/calc_pkg.sv
hw/calc_bypass.sv
hw/calc_pipe_int.sv
hw/calc_pipe_mul.sv
hw/calc_pipe_long.sv
hw/calc_comp_pipe.sv
hw/calc_top.sv
testbench/tb_clkgen.sv
testbench/tb_calc.sv

// ==== testbench/tb_calc.sv ====
// Testbench for the integer back end, runs directed and random traffic against a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_calc;

  import calc_pkg::*;

  localparam int n_random_c    = 300;
  localparam int total_instr_c = n_random_c + 120;

  logic          clk;
  logic          rst;
  dispatch_pkt_t dispatch_pkt;
  wb_pkt_t       iwb_pkt;
  logic          idiv_busy;

  data_t     arch_rf [32];
  data_t     golden_rf [32];
  int        due_q [$];
  wb_pkt_t   exp_q [$];
  wb_pkt_t   div_exp;
  logic      div_outstanding;
  int        edge_cnt;
  logic      prev_mul;
  logic      prev_div;
  reg_addr_t prev_rd;

  tb_clkgen u_clkgen
  (
    .clk_o (clk),
    .rst_o (rst)
  );

  calc_top u_calc_top
  (
    .clk_i          (clk),
    .rst_i          (rst),
    .dispatch_pkt_i (dispatch_pkt),
    .iwb_pkt_o      (iwb_pkt),
    .idiv_busy_o    (idiv_busy)
  );

  function automatic data_t calc_ref(calc_op_e op, data_t a, data_t b);
    logic [2*data_width_c-1:0] prod;
    prod = {{data_width_c{1'b0}}, a} * {{data_width_c{1'b0}}, b};
    case (op)
      op_add:  return a + b;
      op_sub:  return a - b;
      op_and:  return a & b;
      op_xor:  return a ^ b;
      op_sltu: return (a < b) ? data_t'(1) : data_t'(0);
      op_mul:  return prod[data_width_c-1:0];
      op_divu: return (b == '0) ? '1 : a / b;
      default: return (b == '0) ? a : a % b;
    endcase
  endfunction

  task automatic report_error(string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1);
  endtask

  // Data is only compared when a write is expected
  task automatic check_wb(string name, wb_pkt_t got, wb_pkt_t exp);
    if ((got.w_v !== exp.w_v) || (exp.w_v && (got !== exp)))
      report_error($sformatf("Mismatch %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_busy(logic got, logic exp);
    if (got !== exp)
      report_error($sformatf("Mismatch idiv_busy_o got %h expected %h", got, exp));
  endtask

  task automatic drive_op(calc_op_e op, reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
    @(negedge clk);
    dispatch_pkt          = '0;
    dispatch_pkt.v        = 1'b1;
    dispatch_pkt.op       = op;
    dispatch_pkt.rs1_r_v  = 1'b1;
    dispatch_pkt.rs2_r_v  = 1'b1;
    dispatch_pkt.rd_w_v   = 1'b1;
    dispatch_pkt.rs1_addr = rs1;
    dispatch_pkt.rs2_addr = rs2;
    dispatch_pkt.rd_addr  = rd;
    dispatch_pkt.rs1      = arch_rf[rs1];
    dispatch_pkt.rs2      = arch_rf[rs2];
    prev_mul              = (op == op_mul);
    prev_div              = (op inside {op_divu, op_remu});
    prev_rd               = rd;
  endtask

  task automatic drive_idle();
    @(negedge clk);
    dispatch_pkt = '0;
    prev_mul     = 1'b0;
    prev_div     = 1'b0;
  endtask

  // A divide just driven is not yet counted as outstanding
  task automatic wait_div_done();
    while (div_outstanding || prev_div)
      drive_idle();
  endtask

  // Reference bookkeeping and writeback checks, one step per rising edge
  always @(posedge clk)
  begin
    if (!rst)
    begin
      edge_cnt++;
      check_busy(idiv_busy, div_outstanding);
      if ((due_q.size() > 0) && (due_q[0] == edge_cnt))
      begin
        check_wb("iwb_pkt_o", iwb_pkt, exp_q[0]);
        void'(due_q.pop_front());
        void'(exp_q.pop_front());
      end
      else if (iwb_pkt.w_v === 1'b1)
      begin
        if (!div_outstanding)
          report_error("Writeback seen with no instruction outstanding");
        check_wb("iwb_pkt_o", iwb_pkt, div_exp);
        div_outstanding = 1'b0;
      end
      if (iwb_pkt.w_v === 1'b1)
        arch_rf[iwb_pkt.rd_addr] = iwb_pkt.rd_data;
      if (dispatch_pkt.v)
      begin
        wb_pkt_t exp;
        exp.w_v     = 1'b1;
        exp.rd_addr = dispatch_pkt.rd_addr;
        exp.rd_data = calc_ref(dispatch_pkt.op, golden_rf[dispatch_pkt.rs1_addr],
                               golden_rf[dispatch_pkt.rs2_addr]);
        golden_rf[dispatch_pkt.rd_addr] = exp.rd_data;
        if (dispatch_pkt.op inside {op_divu, op_remu})
        begin
          div_exp         = exp;
          div_outstanding = 1'b1;
        end
        else
        begin
          due_q.push_back(edge_cnt + 3);
          exp_q.push_back(exp);
        end
      end
    end
  end

  initial
  begin
    #(longint'(total_instr_c) * (data_width_c + 8) * 4);
    $display("Timeout, the run did not finish in the expected time");
    $display("TB FAILED");
    $fatal(1);
  end

  initial
  begin
    calc_op_e  op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    logic      ok;
    logic      div_pending;
    reg_addr_t div_rd;
    dispatch_pkt    = '0;
    div_outstanding = 1'b0;
    div_exp         = '0;
    edge_cnt        = 0;
    prev_mul        = 1'b0;
    prev_div        = 1'b0;
    prev_rd         = '0;
    void'($urandom(20351));
    for (int i = 0; i < 32; i++)
    begin
      arch_rf[i]   = $urandom();
      golden_rf[i] = arch_rf[i];
    end
    @(negedge rst);
    check_wb("iwb_pkt_o", iwb_pkt, '0);
    check_busy(idiv_busy, 1'b0);

    // Independent ALU ops of every kind
    for (int i = 0; i < 5; i++)
      drive_op(calc_op_e'(i), reg_addr_t'(i + 1), reg_addr_t'(i + 10), reg_addr_t'(i + 16));
    // Dependences at distance 1, 2 and 3
    drive_op(op_add, 5'd1, 5'd2, 5'd3);
    drive_op(op_sub, 5'd4, 5'd1, 5'd1);
    drive_op(op_xor, 5'd5, 5'd2, 5'd6);
    drive_op(op_and, 5'd7, 5'd4, 5'd5);
    drive_op(op_add, 5'd8, 5'd9, 5'd9);
    drive_op(op_sltu, 5'd10, 5'd9, 5'd8);
    drive_op(op_add, 5'd11, 5'd5, 5'd7);
    // Multiply with one bubble before the consumer
    drive_op(op_mul, 5'd12, 5'd6, 5'd7);
    drive_op(op_add, 5'd13, 5'd1, 5'd2);
    drive_op(op_add, 5'd14, 5'd12, 5'd12);
    drive_op(op_mul, 5'd15, 5'd12, 5'd14);
    drive_idle();
    drive_op(op_mul, 5'd16, 5'd15, 5'd15);
    drive_idle();
    drive_idle();
    drive_op(op_add, 5'd17, 5'd16, 5'd15);

    // Divides wait behind back-to-back ALU traffic, zero divisor first
    drive_op(op_xor, 5'd22, 5'd22, 5'd22);
    drive_op(op_divu, 5'd20, 5'd21, 5'd22);
    for (int i = 0; i < 45; i++)
      drive_op(calc_op_e'(i % 5), reg_addr_t'(i % 4 + 1), reg_addr_t'(i % 3 + 2), 5'd6);
    wait_div_done();
    drive_op(op_remu, 5'd23, 5'd21, 5'd22);
    for (int i = 0; i < 40; i++)
      drive_op(op_add, 5'd1, 5'd1, 5'd2);
    wait_div_done();
    drive_op(op_divu, 5'd24, 5'd16, 5'd5);
    wait_div_done();
    drive_op(op_remu, 5'd25, 5'd16, 5'd5);
    wait_div_done();

    // Random mix that follows the issue rules
    for (int i = 0; i < n_random_c; i++)
    begin
      if ($urandom_range(0, 9) == 0)
        drive_idle();
      else
      begin
        // The divide driven last is not yet outstanding
        div_pending = div_outstanding || prev_div;
        div_rd      = prev_div ? prev_rd : div_exp.rd_addr;
        op = calc_op_e'(3'($urandom_range(0, 7)));
        if ((op inside {op_divu, op_remu}) && div_pending)
          op = op_add;
        ok = 1'b0;
        while (!ok)
        begin
          rd  = reg_addr_t'($urandom_range(0, 31));
          rs1 = reg_addr_t'($urandom_range(0, 31));
          rs2 = reg_addr_t'($urandom_range(0, 31));
          ok  = !(prev_mul && ((rs1 == prev_rd) || (rs2 == prev_rd)))
                && !(div_pending && ((rs1 == div_rd)
                     || (rs2 == div_rd) || (rd == div_rd)));
        end
        drive_op(op, rd, rs1, rs2);
      end
    end

    drive_idle();
    while ((due_q.size() != 0) || div_outstanding)
      drive_idle();
    drive_idle();
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/tb_clkgen.sv ====
// Clock and reset source for the testbench, 4 ns clock with reset held for the first 4 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen
  (
    output logic clk_o,
    output logic rst_o
  );

  initial
  begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Released on a falling edge, like every other DUT input
  initial
  begin
    rst_o = 1'b1;
    repeat (4) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire
